// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    // data path width
    localparam int XLEN = 32;

    // machine csr addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // mstatus fields
    localparam int          MSTATUS_MIE_BIT  = 3;
    localparam int          MSTATUS_MPIE_BIT = 7;
    localparam logic [1:0]  MSTATUS_MPP_VAL  = 2'd3;

    // operations carried on the csr bus
    typedef enum logic [2:0] {
        OP_RW   = 3'd0,
        OP_RS   = 3'd1,
        OP_RC   = 3'd2,
        OP_TRAP = 3'd3,
        OP_MRET = 3'd4
    } csr_op_e;

    // requester unit FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_RESP = 2'd2
    } unit_state_e;

endpackage

// ==== rtl/csr_bus_if.sv ====
`timescale 1ns/1ps

interface csr_bus_if;

    logic                       valid;
    logic                       ready;
    csr_pkg::csr_op_e           op;
    logic [11:0]                addr;
    logic [csr_pkg::XLEN-1:0]   wdata;
    logic [csr_pkg::XLEN-1:0]   pc;
    logic [csr_pkg::XLEN-1:0]   cause;
    // old value, valid in the transfer cycle
    logic [csr_pkg::XLEN-1:0]   rdata;

    modport requester (
        output valid, op, addr, wdata, pc, cause,
        input  ready, rdata
    );

    modport responder (
        input  valid, op, addr, wdata, pc, cause,
        output ready, rdata
    );

endinterface

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic         clk,
    input  logic         rst_n,
    csr_bus_if.responder bus
);

    // low two bits of mtvec and mepc are hardwired to zero
    logic [csr_pkg::XLEN-1:2] mtvec_q;
    logic [csr_pkg::XLEN-1:2] mepc_q;
    logic [csr_pkg::XLEN-1:0] mcause_q;
    logic                     mie_q;
    logic                     mpie_q;

    logic [csr_pkg::XLEN-1:0] mstatus_val;
    logic [csr_pkg::XLEN-1:0] mtvec_val;
    logic [csr_pkg::XLEN-1:0] mepc_val;
    logic [csr_pkg::XLEN-1:0] old_val;
    logic [csr_pkg::XLEN-1:0] new_val;
    logic                     fire;

    // never stalls, arbiter handles back-pressure
    assign bus.ready = 1'b1;
    assign fire      = bus.valid & bus.ready;

    assign mtvec_val = {mtvec_q, 2'b00};
    assign mepc_val  = {mepc_q, 2'b00};

    always_comb begin
        mstatus_val = '0;
        mstatus_val[12:11] = csr_pkg::MSTATUS_MPP_VAL;
        mstatus_val[csr_pkg::MSTATUS_MIE_BIT]  = mie_q;
        mstatus_val[csr_pkg::MSTATUS_MPIE_BIT] = mpie_q;
    end

    // address decode, unknown csrs read zero
    always_comb begin
        case (bus.addr)
            csr_pkg::CSR_MSTATUS: old_val = mstatus_val;
            csr_pkg::CSR_MTVEC:   old_val = mtvec_val;
            csr_pkg::CSR_MEPC:    old_val = mepc_val;
            csr_pkg::CSR_MCAUSE:  old_val = mcause_q;
            default:              old_val = '0;
        endcase
    end

    always_comb begin
        case (bus.op)
            csr_pkg::OP_RW: new_val = bus.wdata;
            csr_pkg::OP_RS: new_val = old_val | bus.wdata;
            csr_pkg::OP_RC: new_val = old_val & ~bus.wdata;
            default:        new_val = old_val;
        endcase
    end

    // trap returns the handler base, mret the saved pc
    assign bus.rdata = (bus.op == csr_pkg::OP_TRAP) ? mtvec_val :
                       (bus.op == csr_pkg::OP_MRET) ? mepc_val  : old_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q  <= '0;
            mepc_q   <= '0;
            mcause_q <= '0;
            mie_q    <= 1'b0;
            mpie_q   <= 1'b0;
        end else if (fire) begin
            case (bus.op)
                csr_pkg::OP_TRAP: begin
                    mepc_q   <= bus.pc[csr_pkg::XLEN-1:2];
                    mcause_q <= bus.cause;
                    mpie_q   <= mie_q;
                    mie_q    <= 1'b0;
                end
                csr_pkg::OP_MRET: begin
                    mie_q  <= mpie_q;
                    mpie_q <= 1'b1;
                end
                csr_pkg::OP_RW, csr_pkg::OP_RS, csr_pkg::OP_RC: begin
                    case (bus.addr)
                        csr_pkg::CSR_MSTATUS: begin
                            // only MIE and MPIE are writable
                            mie_q  <= new_val[csr_pkg::MSTATUS_MIE_BIT];
                            mpie_q <= new_val[csr_pkg::MSTATUS_MPIE_BIT];
                        end
                        csr_pkg::CSR_MTVEC:  mtvec_q  <= new_val[csr_pkg::XLEN-1:2];
                        csr_pkg::CSR_MEPC:   mepc_q   <= new_val[csr_pkg::XLEN-1:2];
                        csr_pkg::CSR_MCAUSE: mcause_q <= new_val;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/csr_arbiter.sv ====
`timescale 1ns/1ps

module csr_arbiter (
    csr_bus_if.responder trap_bus,
    csr_bus_if.responder instr_bus,
    csr_bus_if.requester file_bus
);

    logic grant_trap;

    // fixed priority, trap side always wins
    assign grant_trap = trap_bus.valid;

    // request path
    assign file_bus.valid = trap_bus.valid | instr_bus.valid;
    assign file_bus.op    = grant_trap ? trap_bus.op    : instr_bus.op;
    assign file_bus.addr  = grant_trap ? trap_bus.addr  : instr_bus.addr;
    assign file_bus.wdata = grant_trap ? trap_bus.wdata : instr_bus.wdata;
    assign file_bus.pc    = grant_trap ? trap_bus.pc    : instr_bus.pc;
    assign file_bus.cause = grant_trap ? trap_bus.cause : instr_bus.cause;

    // response path, granted side only
    assign trap_bus.ready  = grant_trap & file_bus.ready;
    assign trap_bus.rdata  = grant_trap ? file_bus.rdata : '0;

    // instruction side stalls while a trap holds the bus
    assign instr_bus.ready = ~grant_trap & file_bus.ready;
    assign instr_bus.rdata = grant_trap ? '0 : file_bus.rdata;

endmodule

// ==== rtl/csr_instr_unit.sv ====
`timescale 1ns/1ps

module csr_instr_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid_i,
    output logic                     instr_ready_o,
    input  logic [csr_pkg::XLEN-1:0] instr_i,
    input  logic [csr_pkg::XLEN-1:0] rs1_data_i,
    output logic                     rd_valid_o,
    input  logic                     rd_ready_i,
    output logic [csr_pkg::XLEN-1:0] rd_data_o,
    csr_bus_if.requester             bus
);

    csr_pkg::unit_state_e     state_q;
    csr_pkg::csr_op_e         op_d;
    csr_pkg::csr_op_e         op_q;
    logic [11:0]              addr_q;
    logic [csr_pkg::XLEN-1:0] operand_d;
    logic [csr_pkg::XLEN-1:0] operand_q;
    logic [csr_pkg::XLEN-1:0] result_q;
    logic [2:0]               funct3;
    logic                     accept;
    logic                     fire;

    assign funct3 = instr_i[14:12];
    assign accept = instr_valid_i & instr_ready_o;
    assign fire   = bus.valid & bus.ready;

    always_comb begin
        case (funct3[1:0])
            2'b01:   op_d = csr_pkg::OP_RW;
            2'b10:   op_d = csr_pkg::OP_RS;
            default: op_d = csr_pkg::OP_RC;
        endcase
    end

    // immediate forms use the zero-extended rs1 field
    assign operand_d = funct3[2] ? {{(csr_pkg::XLEN-5){1'b0}}, instr_i[19:15]} : rs1_data_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= csr_pkg::ST_IDLE;
        end else begin
            case (state_q)
                csr_pkg::ST_IDLE: if (accept) state_q <= csr_pkg::ST_REQ;
                csr_pkg::ST_REQ:  if (fire) state_q <= csr_pkg::ST_RESP;
                csr_pkg::ST_RESP: if (rd_ready_i) state_q <= csr_pkg::ST_IDLE;
                default:          state_q <= csr_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= op_d;
            addr_q    <= instr_i[31:20];
            operand_q <= operand_d;
        end
        // old csr value becomes the rd result
        if (fire) begin
            result_q <= bus.rdata;
        end
    end

    assign instr_ready_o = (state_q == csr_pkg::ST_IDLE);
    assign rd_valid_o    = (state_q == csr_pkg::ST_RESP);
    assign rd_data_o     = result_q;

    assign bus.valid = (state_q == csr_pkg::ST_REQ);
    assign bus.op    = op_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = operand_q;
    // trap fields unused for register ops
    assign bus.pc    = '0;
    assign bus.cause = '0;

endmodule

// ==== rtl/csr_trap_unit.sv ====
`timescale 1ns/1ps

module csr_trap_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     trap_valid_i,
    output logic                     trap_ready_o,
    input  logic                     trap_mret_i,
    input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
    input  logic [csr_pkg::XLEN-1:0] trap_cause_i,
    output logic                     redirect_valid_o,
    input  logic                     redirect_ready_i,
    output logic [csr_pkg::XLEN-1:0] redirect_pc_o,
    csr_bus_if.requester             bus
);

    csr_pkg::unit_state_e     state_q;
    csr_pkg::csr_op_e         op_q;
    logic [csr_pkg::XLEN-1:0] pc_q;
    logic [csr_pkg::XLEN-1:0] cause_q;
    logic [csr_pkg::XLEN-1:0] target_q;
    logic                     accept;
    logic                     fire;

    assign accept = trap_valid_i & trap_ready_o;
    assign fire   = bus.valid & bus.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= csr_pkg::ST_IDLE;
        end else begin
            case (state_q)
                csr_pkg::ST_IDLE: if (accept) state_q <= csr_pkg::ST_REQ;
                csr_pkg::ST_REQ:  if (fire) state_q <= csr_pkg::ST_RESP;
                csr_pkg::ST_RESP: if (redirect_ready_i) state_q <= csr_pkg::ST_IDLE;
                default:          state_q <= csr_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= trap_mret_i ? csr_pkg::OP_MRET : csr_pkg::OP_TRAP;
            pc_q    <= trap_pc_i;
            cause_q <= trap_cause_i;
        end
        // mtvec on trap entry, mepc on mret
        if (fire) begin
            target_q <= bus.rdata;
        end
    end

    assign trap_ready_o     = (state_q == csr_pkg::ST_IDLE);
    assign redirect_valid_o = (state_q == csr_pkg::ST_RESP);
    assign redirect_pc_o    = target_q;

    assign bus.valid = (state_q == csr_pkg::ST_REQ);
    assign bus.op    = op_q;
    assign bus.addr  = '0;
    assign bus.wdata = '0;
    assign bus.pc    = pc_q;
    assign bus.cause = cause_q;

endmodule

// ==== rtl/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // csr instruction in
    input  logic                     instr_valid_i,
    output logic                     instr_ready_o,
    input  logic [csr_pkg::XLEN-1:0] instr_i,
    input  logic [csr_pkg::XLEN-1:0] rs1_data_i,
    // rd result out
    output logic                     rd_valid_o,
    input  logic                     rd_ready_i,
    output logic [csr_pkg::XLEN-1:0] rd_data_o,
    // trap and mret events in
    input  logic                     trap_valid_i,
    output logic                     trap_ready_o,
    input  logic                     trap_mret_i,
    input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
    input  logic [csr_pkg::XLEN-1:0] trap_cause_i,
    // fetch redirect out
    output logic                     redirect_valid_o,
    input  logic                     redirect_ready_i,
    output logic [csr_pkg::XLEN-1:0] redirect_pc_o
);

    csr_bus_if instr_bus ();
    csr_bus_if trap_bus ();
    csr_bus_if file_bus ();

    csr_instr_unit u_instr (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .rd_valid_o    (rd_valid_o),
        .rd_ready_i    (rd_ready_i),
        .rd_data_o     (rd_data_o),
        .bus           (instr_bus.requester)
    );

    csr_trap_unit u_trap (
        .clk              (clk),
        .rst_n            (rst_n),
        .trap_valid_i     (trap_valid_i),
        .trap_ready_o     (trap_ready_o),
        .trap_mret_i      (trap_mret_i),
        .trap_pc_i        (trap_pc_i),
        .trap_cause_i     (trap_cause_i),
        .redirect_valid_o (redirect_valid_o),
        .redirect_ready_i (redirect_ready_i),
        .redirect_pc_o    (redirect_pc_o),
        .bus              (trap_bus.requester)
    );

    csr_arbiter u_arb (
        .trap_bus  (trap_bus.responder),
        .instr_bus (instr_bus.responder),
        .file_bus  (file_bus.requester)
    );

    csr_file u_file (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (file_bus.responder)
    );

endmodule

// ==== tb/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;

    logic        clk;
    logic        rst_n;
    logic        instr_valid_i;
    logic        instr_ready_o;
    logic [31:0] instr_i;
    logic [31:0] rs1_data_i;
    logic        rd_valid_o;
    logic        rd_ready_i;
    logic [31:0] rd_data_o;
    logic        trap_valid_i;
    logic        trap_ready_o;
    logic        trap_mret_i;
    logic [31:0] trap_pc_i;
    logic [31:0] trap_cause_i;
    logic        redirect_valid_o;
    logic        redirect_ready_i;
    logic [31:0] redirect_pc_o;

    // shadow copy of the machine csrs
    logic        m_mie;
    logic        m_mpie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    logic [31:0] exp_rd;
    logic [31:0] exp_redir;
    string       test_name;
    int          seed;
    int          max_stall;
    int          wait_limit;
    int          n_instr;
    int          n_trap;
    int          rd_count;
    int          redir_count;
    logic        rd_held_q;
    logic        redir_held_q;

    csr_top u_dut (.*);

    always #20 clk = ~clk;

    // a valid not held over from a stalled cycle is a new result
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_count     <= 0;
            redir_count  <= 0;
            rd_held_q    <= 1'b0;
            redir_held_q <= 1'b0;
        end else begin
            if (rd_valid_o && !rd_held_q) rd_count <= rd_count + 1;
            if (redirect_valid_o && !redir_held_q) redir_count <= redir_count + 1;
            rd_held_q    <= rd_valid_o && !rd_ready_i;
            redir_held_q <= redirect_valid_o && !redirect_ready_i;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("Mismatch in %s: expected %08h, actual %08h", name, exp, act));
    endtask

    // results checked on each output handshake
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_o && rd_ready_i |-> rd_data_o == exp_rd)
        else report_mismatch(test_name, $sampled(exp_rd), $sampled(rd_data_o));

    assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_o && redirect_ready_i |-> redirect_pc_o == exp_redir)
        else report_mismatch(test_name, $sampled(exp_redir), $sampled(redirect_pc_o));

    // held outputs under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid_o && !rd_ready_i |=> rd_valid_o && !instr_ready_o && $stable(rd_data_o))
        else fail_run("rd result or its valid changed while the consumer stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_o && !redirect_ready_i |=>
            redirect_valid_o && !trap_ready_o && $stable(redirect_pc_o))
        else fail_run("redirect or its valid changed while the consumer stalled");

    function automatic logic [31:0] read_csr(input logic [11:0] addr);
        logic [31:0] mstatus;
        mstatus    = 32'h1800;
        mstatus[3] = m_mie;
        mstatus[7] = m_mpie;
        case (addr)
            csr_pkg::CSR_MSTATUS: return mstatus;
            csr_pkg::CSR_MTVEC:   return m_mtvec;
            csr_pkg::CSR_MEPC:    return m_mepc;
            csr_pkg::CSR_MCAUSE:  return m_mcause;
            default:              return 32'h0;
        endcase
    endfunction

    // returns the old value and applies the masked write
    function automatic logic [31:0] model_csr(input logic [2:0] f3, input logic [11:0] addr,
                                              input logic [31:0] rs1);
        logic [31:0] opnd;
        logic [31:0] old;
        logic [31:0] upd;
        opnd = f3[2] ? {27'd0, rs1[4:0]} : rs1;
        old  = read_csr(addr);
        case (f3[1:0])
            2'b01:   upd = opnd;
            2'b10:   upd = old | opnd;
            default: upd = old & ~opnd;
        endcase
        case (addr)
            csr_pkg::CSR_MSTATUS: begin
                m_mie  = upd[3];
                m_mpie = upd[7];
            end
            csr_pkg::CSR_MTVEC:  m_mtvec  = upd & ~32'h3;
            csr_pkg::CSR_MEPC:   m_mepc   = upd & ~32'h3;
            csr_pkg::CSR_MCAUSE: m_mcause = upd;
            default: ;
        endcase
        return old;
    endfunction

    function automatic logic [31:0] model_trap(input logic mret, input logic [31:0] pc,
                                               input logic [31:0] cause);
        logic [31:0] target;
        if (mret) begin
            target = m_mepc;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
        end else begin
            target   = m_mtvec;
            m_mepc   = pc & ~32'h3;
            m_mcause = cause;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end
        return target;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // one bounded step of a wait loop
    task automatic wait_step(inout int n, input string what);
        n++;
        if (n > wait_limit) fail_run({"timeout waiting for ", what});
        tick();
    endtask

    task automatic run_instr(input logic [31:0] instr, input logic [31:0] rs1);
        int n;
        int stall;
        instr_i       = instr;
        rs1_data_i    = rs1;
        instr_valid_i = 1'b1;
        n = 0;
        while (!instr_ready_o) wait_step(n, "instr_ready_o");
        tick();
        instr_valid_i = 1'b0;
        n = 0;
        while (!rd_valid_o) wait_step(n, "rd_valid_o");
        stall = $unsigned($random(seed)) % (max_stall + 1);
        repeat (stall) tick();
        rd_ready_i = 1'b1;
        tick();
        rd_ready_i = 1'b0;
        n_instr++;
    endtask

    task automatic run_trap(input logic mret, input logic [31:0] pc, input logic [31:0] cause);
        int n;
        int stall;
        trap_mret_i  = mret;
        trap_pc_i    = pc;
        trap_cause_i = cause;
        trap_valid_i = 1'b1;
        n = 0;
        while (!trap_ready_o) wait_step(n, "trap_ready_o");
        tick();
        trap_valid_i = 1'b0;
        n = 0;
        while (!redirect_valid_o) wait_step(n, "redirect_valid_o");
        stall = $unsigned($random(seed)) % (max_stall + 1);
        repeat (stall) tick();
        redirect_ready_i = 1'b1;
        tick();
        redirect_ready_i = 1'b0;
        n_trap++;
    endtask

    task automatic do_csr(input logic [2:0] f3, input logic [11:0] addr, input logic [31:0] rs1);
        exp_rd = model_csr(f3, addr, rs1);
        run_instr({addr, rs1[4:0], f3, 5'd1, 7'h73}, rs1);
    endtask

    task automatic do_trap(input logic mret, input logic [31:0] pc, input logic [31:0] cause);
        exp_redir = model_trap(mret, pc, cause);
        run_trap(mret, pc, cause);
    endtask

    // trap wins the bus, so the model applies it first
    task automatic contend(input logic mret, input logic [31:0] pc, input logic [31:0] cause,
                           input logic [2:0] f3, input logic [11:0] addr,
                           input logic [31:0] rs1);
        exp_redir = model_trap(mret, pc, cause);
        exp_rd    = model_csr(f3, addr, rs1);
        fork
            run_trap(mret, pc, cause);
            run_instr({addr, rs1[4:0], f3, 5'd1, 7'h73}, rs1);
        join
    endtask

    task automatic read_all();
        do_csr(3'b010, csr_pkg::CSR_MSTATUS, 32'h0);
        do_csr(3'b010, csr_pkg::CSR_MTVEC, 32'h0);
        do_csr(3'b010, csr_pkg::CSR_MEPC, 32'h0);
        do_csr(3'b010, csr_pkg::CSR_MCAUSE, 32'h0);
        do_csr(3'b110, 12'h7c0, 32'h0);
    endtask

    function automatic logic [11:0] pick_addr();
        logic [1:0] sel;
        sel = 2'($random(seed));
        case (sel)
            2'd0:    return csr_pkg::CSR_MSTATUS;
            2'd1:    return csr_pkg::CSR_MTVEC;
            2'd2:    return csr_pkg::CSR_MEPC;
            default: return csr_pkg::CSR_MCAUSE;
        endcase
    endfunction

    // any of csrrw, csrrs, csrrc and their immediate forms
    function automatic logic [2:0] pick_f3();
        logic [2:0] f3;
        f3 = 3'($random(seed));
        if (f3[1:0] == 2'b00) f3[1:0] = 2'b01;
        return f3;
    endfunction

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        rs1_data_i = '0;
        rd_ready_i = 1'b0;
        trap_valid_i = 1'b0;
        trap_mret_i = 1'b0;
        trap_pc_i = '0;
        trap_cause_i = '0;
        redirect_ready_i = 1'b0;
        m_mie = 1'b0;
        m_mpie = 1'b0;
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        exp_rd = '0;
        exp_redir = '0;
        seed = 32'h5ac5;
        max_stall = 3;
        wait_limit = 100;
        n_instr = 0;
        n_trap = 0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        assert (instr_ready_o && trap_ready_o && !rd_valid_o && !redirect_valid_o)
            else fail_run("handshake outputs are wrong after reset");
        read_all();

        test_name = "unknown_write";
        do_csr(3'b001, 12'h7c0, 32'hffff_ffff);
        do_csr(3'b010, 12'h7c0, 32'h0000_00f0);
        read_all();

        test_name = "register_ops";
        repeat (60) do_csr(pick_f3(), pick_addr(), $random(seed));
        read_all();

        test_name = "trap_entry";
        do_csr(3'b001, csr_pkg::CSR_MTVEC, $random(seed));
        do_csr(3'b010, csr_pkg::CSR_MSTATUS, 32'h8);
        do_trap(1'b0, $random(seed), $random(seed));
        read_all();

        test_name = "mret";
        do_trap(1'b1, $random(seed), $random(seed));
        read_all();

        test_name = "contention";
        repeat (20) begin
            contend(1'($random(seed)), $random(seed), $random(seed),
                    pick_f3(), pick_addr(), $random(seed));
        end
        read_all();

        // long consumer stalls
        test_name = "back_pressure";
        max_stall = 8;
        repeat (15) begin
            contend(1'($random(seed)), $random(seed), $random(seed),
                    pick_f3(), pick_addr(), $random(seed));
            do_csr(pick_f3(), pick_addr(), $random(seed));
        end
        read_all();

        tick();
        if (rd_count == n_instr && redir_count == n_trap) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("a result was lost or repeated on an output");
        end
    end

endmodule

// ==== flist.f ====
rtl/csr_pkg.sv
rtl/csr_bus_if.sv
rtl/csr_file.sv
rtl/csr_arbiter.sv
rtl/csr_instr_unit.sv
rtl/csr_trap_unit.sv
rtl/csr_top.sv
tb/csr_tb.sv

// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= csr_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLIST     ?= flist.f

SRCS := $(wildcard rtl/*.sv tb/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
